//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsystem -f vlog.f \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_mem_subsystem > sim.log 2>&1
cat sim.log
grep -q "^TEST PASSED$" sim.log && exit 0 || exit 1

//--- source/cache_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module cache_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_pkg::dfp_req_t     inst_req,
    output mem_pkg::dfp_rsp_t     inst_rsp,
    input  mem_pkg::dfp_req_t     data_req,
    output mem_pkg::dfp_rsp_t     data_rsp,
    output logic [31:0]           bmem_addr,
    output logic                  bmem_read,
    output logic                  bmem_write,
    output logic [`BEAT_BITS-1:0] bmem_wdata,
    input  logic                  bmem_ready,
    input  logic [`BEAT_BITS-1:0] bmem_rdata,
    input  logic [31:0]           bmem_raddr,
    input  logic                  bmem_rvalid
);
    import mem_pkg::*;

    localparam int CNT_W = $clog2(`BEATS);
    localparam int TBL_W = $clog2(`TABLE_DEPTH);

    servicing_t sel;

    logic [CNT_W-1:0]      rd_cnt;
    logic [CNT_W-1:0]      wr_cnt;
    logic [`BEAT_BITS-1:0] rd_buf [`BEATS-1];
    logic [`BEAT_BITS-1:0] wr_buf [`BEATS-1];
    logic [31:0]           wb_addr;
    logic [`LINE_BITS-1:0] fill_line;

    address_entry_t req_table [`TABLE_DEPTH];

    logic             free_found;
    logic [TBL_W-1:0] free_idx;
    logic             match_found;
    logic [TBL_W-1:0] match_idx;
    logic             inst_outstanding;
    logic             data_outstanding;
    logic             table_full;
    logic             inst_want;
    logic             data_want;
    logic             write_busy;
    logic             write_done;
    logic             last_beat;
    logic             route_data;

    // Table scan for the first free slot, the entry of the returning line and who waits
    always_comb begin
        free_found       = 1'b0;
        free_idx         = '0;
        match_found      = 1'b0;
        match_idx        = '0;
        inst_outstanding = 1'b0;
        data_outstanding = 1'b0;
        for (int i = 0; i < `TABLE_DEPTH; i++) begin
            if (!req_table[i].valid && !free_found) begin
                free_found = 1'b1;
                free_idx   = TBL_W'(i);
            end
            if (req_table[i].valid && req_table[i].addr == bmem_raddr && !match_found) begin
                match_found = 1'b1;
                match_idx   = TBL_W'(i);
            end
            if (req_table[i].valid) begin
                if (req_table[i].is_for_data_cache) begin
                    data_outstanding = 1'b1;
                end else begin
                    inst_outstanding = 1'b1;
                end
            end
        end
    end

    assign table_full = !free_found;
    assign write_busy = (wr_cnt != '0);
    assign inst_want  = inst_req.read && !inst_outstanding;
    assign data_want  = data_req.write || (data_req.read && !data_outstanding);

    // Data goes first and a running write burst keeps the port
    always_comb begin
        if (write_busy || data_want) begin
            sel = SERVE_DATA;
        end else begin
            sel = SERVE_INST;
        end
    end

    always_comb begin
        bmem_addr  = data_req.addr;
        bmem_wdata = data_req.wdata[`BEAT_BITS-1:0];
        bmem_read  = 1'b0;
        bmem_write = 1'b0;
        if (bmem_ready) begin
            if (write_busy) begin
                bmem_addr  = wb_addr;
                bmem_wdata = wr_buf[wr_cnt - CNT_W'(1)];
                bmem_write = 1'b1;
            end else if (sel == SERVE_DATA && data_req.write) begin
                // Lowest beat leaves straight from the request
                bmem_write = 1'b1;
            end else if (sel == SERVE_DATA && data_want && !table_full) begin
                bmem_read = 1'b1;
            end else if (sel == SERVE_INST && inst_want && !table_full) begin
                bmem_addr = inst_req.addr;
                bmem_read = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_cnt <= '0;
            rd_cnt <= '0;
        end else begin
            if (bmem_write) begin
                wr_cnt <= wr_cnt + CNT_W'(1);
            end
            if (bmem_rvalid) begin
                rd_cnt <= rd_cnt + CNT_W'(1);
            end
        end
    end

    // Upper beats of the burst are kept for the following cycles
    always_ff @(posedge clk) begin
        if (bmem_write && !write_busy) begin
            wb_addr <= data_req.addr;
            for (int b = 0; b < `BEATS - 1; b++) begin
                wr_buf[b] <= data_req.wdata[(b + 1) * `BEAT_BITS +: `BEAT_BITS];
            end
        end
        if (bmem_rvalid && !last_beat) begin
            rd_buf[rd_cnt] <= bmem_rdata;
        end
    end

    assign last_beat  = bmem_rvalid && (rd_cnt == CNT_W'(`BEATS - 1));
    assign write_done = bmem_write && (wr_cnt == CNT_W'(`BEATS - 1));
    assign route_data = req_table[match_idx].is_for_data_cache;

    // Fourth beat is forwarded without a buffer stage
    always_comb begin
        fill_line[`LINE_BITS-1 -: `BEAT_BITS] = bmem_rdata;
        for (int b = 0; b < `BEATS - 1; b++) begin
            fill_line[b * `BEAT_BITS +: `BEAT_BITS] = rd_buf[b];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `TABLE_DEPTH; i++) begin
                req_table[i] <= '0;
            end
        end else begin
            if (bmem_read) begin
                req_table[free_idx].valid             <= 1'b1;
                req_table[free_idx].is_for_data_cache <= (sel == SERVE_DATA);
                req_table[free_idx].addr              <= bmem_addr;
            end
            // Slot being freed is valid, so never the one being filled
            if (last_beat && match_found) begin
                req_table[match_idx].valid <= 1'b0;
            end
        end
    end

    assign inst_rsp.rdata = fill_line;
    assign inst_rsp.resp  = last_beat && match_found && !route_data;
    assign data_rsp.rdata = fill_line;
    assign data_rsp.resp  = write_done || (last_beat && match_found && route_data);

    one_command_a: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read && bmem_write));

    line_has_owner_a: assert property (@(posedge clk) disable iff (rst)
        last_beat |-> match_found);

    no_read_when_full_a: assert property (@(posedge clk) disable iff (rst)
        bmem_read |-> !table_full);

endmodule

`default_nettype wire

//--- source/data_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module data_cache (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       ufp_addr,
    input  logic              ufp_rmask,
    input  logic [3:0]        ufp_wmask,
    input  logic [31:0]       ufp_wdata,
    output logic [31:0]       ufp_rdata,
    output logic              ufp_resp,
    output mem_pkg::dfp_req_t dfp_req,
    input  mem_pkg::dfp_rsp_t dfp_rsp
);
    import mem_pkg::*;

    localparam int OFF_W = $clog2(`LINE_BITS / 8);
    localparam int IDX_W = $clog2(`CACHE_SETS);
    localparam int TAG_W = 32 - OFF_W - IDX_W;

    cache_state_t state, next_state;

    logic [`LINE_BITS-1:0]  data_arr [`CACHE_SETS];
    logic [TAG_W-1:0]       tag_arr  [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_arr;
    logic [`CACHE_SETS-1:0] dirty_arr;

    logic [IDX_W-1:0]      idx;
    logic [TAG_W-1:0]      tag;
    logic [OFF_W-3:0]      word_sel;
    logic                  ufp_req;
    logic                  is_write;
    logic                  hit;
    logic [`LINE_BITS-1:0] line_data;
    logic [`LINE_BITS-1:0] merged_line;

    assign idx       = ufp_addr[OFF_W +: IDX_W];
    assign tag       = ufp_addr[31 -: TAG_W];
    assign word_sel  = ufp_addr[OFF_W-1:2];
    assign is_write  = |ufp_wmask;
    assign ufp_req   = ufp_rmask || is_write;
    assign line_data = data_arr[idx];
    assign hit       = valid_arr[idx] && (tag_arr[idx] == tag);

    assign ufp_rdata = line_data[int'(word_sel) * 32 +: 32];
    assign ufp_resp  = (state == COMPARE) && hit;

    // Byte lanes of the addressed word replaced under the write mask
    always_comb begin
        merged_line = line_data;
        for (int b = 0; b < 4; b++) begin
            if (ufp_wmask[b]) begin
                merged_line[int'(word_sel) * 32 + 8 * b +: 8] = ufp_wdata[8 * b +: 8];
            end
        end
    end

    always_comb begin
        dfp_req       = '0;
        dfp_req.addr  = {tag, idx, {OFF_W{1'b0}}};
        dfp_req.wdata = line_data;
        if (state == WRITEBACK) begin
            // Victim line goes back to its own address
            dfp_req.addr  = {tag_arr[idx], idx, {OFF_W{1'b0}}};
            dfp_req.write = 1'b1;
        end else if (state == ALLOCATE) begin
            dfp_req.read = 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (ufp_req) next_state = COMPARE;
            end
            COMPARE: begin
                if (hit) begin
                    next_state = IDLE;
                end else if (valid_arr[idx] && dirty_arr[idx]) begin
                    next_state = WRITEBACK;
                end else begin
                    next_state = ALLOCATE;
                end
            end
            WRITEBACK: begin
                if (dfp_rsp.resp) next_state = ALLOCATE;
            end
            ALLOCATE: begin
                if (dfp_rsp.resp) next_state = COMPARE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            valid_arr <= '0;
            dirty_arr <= '0;
        end else begin
            state <= next_state;
            if (state == COMPARE && hit && is_write) begin
                dirty_arr[idx] <= 1'b1;
            end else if (state == ALLOCATE && dfp_rsp.resp) begin
                valid_arr[idx] <= 1'b1;
                dirty_arr[idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == COMPARE && hit && is_write) begin
            data_arr[idx] <= merged_line;
        end else if (state == ALLOCATE && dfp_rsp.resp) begin
            data_arr[idx] <= dfp_rsp.rdata;
            tag_arr[idx]  <= tag;
        end
    end

    no_read_write_a: assert property (@(posedge clk) disable iff (rst)
        !(dfp_req.read && dfp_req.write));

endmodule

`default_nettype wire

//--- source/inst_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module inst_cache #(
    parameter int SS = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [31:0]        ufp_addr,
    input  logic               ufp_rmask,
    output logic [32*SS-1:0]   ufp_rdata,
    output logic               ufp_resp,
    output mem_pkg::dfp_req_t  dfp_req,
    input  mem_pkg::dfp_rsp_t  dfp_rsp
);
    import mem_pkg::*;

    localparam int OFF_W = $clog2(`LINE_BITS / 8);
    localparam int IDX_W = $clog2(`CACHE_SETS);
    localparam int TAG_W = 32 - OFF_W - IDX_W;

    cache_state_t state, next_state;

    logic [`LINE_BITS-1:0] data_arr [`CACHE_SETS];
    logic [TAG_W-1:0]      tag_arr  [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_arr;

    logic [IDX_W-1:0]     idx;
    logic [TAG_W-1:0]     tag;
    logic [OFF_W-3:0]     word_sel;
    logic                 hit;
    logic [`LINE_BITS-1:0] line_data;

    assign idx       = ufp_addr[OFF_W +: IDX_W];
    assign tag       = ufp_addr[31 -: TAG_W];
    assign word_sel  = ufp_addr[OFF_W-1:2];
    assign line_data = data_arr[idx];
    assign hit       = valid_arr[idx] && (tag_arr[idx] == tag);

    // Fetch packet starts at the requested word and never crosses the line
    assign ufp_rdata = line_data[int'(word_sel) * 32 +: 32 * SS];
    assign ufp_resp  = (state == COMPARE) && hit;

    always_comb begin
        dfp_req       = '0;
        dfp_req.addr  = {ufp_addr[31:OFF_W], {OFF_W{1'b0}}};
        dfp_req.read  = (state == ALLOCATE);
        dfp_req.write = 1'b0;
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:     if (ufp_rmask) next_state = COMPARE;
            COMPARE:  next_state = hit ? IDLE : ALLOCATE;
            // Filled line is checked again, so the hit path gives the response
            ALLOCATE: if (dfp_rsp.resp) next_state = COMPARE;
            default:  next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            valid_arr <= '0;
        end else begin
            state <= next_state;
            if (state == ALLOCATE && dfp_rsp.resp) begin
                valid_arr[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ALLOCATE && dfp_rsp.resp) begin
            data_arr[idx] <= dfp_rsp.rdata;
            tag_arr[idx]  <= tag;
        end
    end

    // Read-only cache never writes a line back
    no_write_a: assert property (@(posedge clk) disable iff (rst)
        !dfp_req.write);

endmodule

`default_nettype wire

//--- source/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// One cache line and the beats that carry it over the banked memory port
`define LINE_BITS 256
`define BEAT_BITS 64
`define BEATS 4

// Sets per direct-mapped cache
`define CACHE_SETS 16

// Outstanding memory reads the arbiter can track
`define TABLE_DEPTH 4

`endif

//--- source/mem_pkg.sv
`default_nettype none

`include "mem_macros.svh"

package mem_pkg;

    // Current owner of the shared memory port
    typedef enum logic {
        SERVE_INST = 1'b0,
        SERVE_DATA = 1'b1
    } servicing_t;

    // Cache controller states, shared by both caches
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        COMPARE   = 2'd1,
        WRITEBACK = 2'd2,
        ALLOCATE  = 2'd3
    } cache_state_t;

    // Cache to arbiter, one full line per request
    typedef struct packed {
        logic [31:0]           addr;
        logic                  read;
        logic                  write;
        logic [`LINE_BITS-1:0] wdata;
    } dfp_req_t;

    // Arbiter to cache, resp pulses for one cycle
    typedef struct packed {
        logic [`LINE_BITS-1:0] rdata;
        logic                  resp;
    } dfp_rsp_t;

    // One outstanding line read
    typedef struct packed {
        logic        valid;
        logic        is_for_data_cache;
        logic [31:0] addr;
    } address_entry_t;

endpackage

`default_nettype wire

//--- source/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module mem_subsystem #(
    parameter int SS = 2
) (
    input  logic                  clk,
    input  logic                  rst,

    // Instruction fetch port
    input  logic [31:0]           imem_addr,
    input  logic                  imem_rmask,
    output logic [32*SS-1:0]      imem_rdata,
    output logic                  imem_resp,

    // Load and store port
    input  logic [31:0]           dmem_addr,
    input  logic                  dmem_rmask,
    input  logic [3:0]            dmem_wmask,
    input  logic [31:0]           dmem_wdata,
    output logic [31:0]           dmem_rdata,
    output logic                  dmem_resp,

    // Banked memory
    output logic [31:0]           bmem_addr,
    output logic                  bmem_read,
    output logic                  bmem_write,
    output logic [`BEAT_BITS-1:0] bmem_wdata,
    input  logic                  bmem_ready,
    input  logic [`BEAT_BITS-1:0] bmem_rdata,
    input  logic [31:0]           bmem_raddr,
    input  logic                  bmem_rvalid
);
    import mem_pkg::*;

    dfp_req_t inst_req;
    dfp_rsp_t inst_rsp;
    dfp_req_t data_req;
    dfp_rsp_t data_rsp;

    inst_cache #(
        .SS(SS)
    ) inst_cache_i (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (imem_addr),
        .ufp_rmask (imem_rmask),
        .ufp_rdata (imem_rdata),
        .ufp_resp  (imem_resp),
        .dfp_req   (inst_req),
        .dfp_rsp   (inst_rsp)
    );

    data_cache data_cache_i (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (dmem_addr),
        .ufp_rmask (dmem_rmask),
        .ufp_wmask (dmem_wmask),
        .ufp_wdata (dmem_wdata),
        .ufp_rdata (dmem_rdata),
        .ufp_resp  (dmem_resp),
        .dfp_req   (data_req),
        .dfp_rsp   (data_rsp)
    );

    cache_arbiter cache_arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .inst_req    (inst_req),
        .inst_rsp    (inst_rsp),
        .data_req    (data_req),
        .data_rsp    (data_rsp),
        .bmem_addr   (bmem_addr),
        .bmem_read   (bmem_read),
        .bmem_write  (bmem_write),
        .bmem_wdata  (bmem_wdata),
        .bmem_ready  (bmem_ready),
        .bmem_rdata  (bmem_rdata),
        .bmem_raddr  (bmem_raddr),
        .bmem_rvalid (bmem_rvalid)
    );

endmodule

`default_nettype wire

//--- testbench/bmem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module bmem_model (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           addr,
    input  logic                  read,
    input  logic                  write,
    input  logic [`BEAT_BITS-1:0] wdata,
    output logic                  ready,
    output logic [`BEAT_BITS-1:0] rdata,
    output logic [31:0]           raddr,
    output logic                  rvalid
);
    localparam int LATENCY = 3;

    logic [`LINE_BITS-1:0] lines [logic [31:0]];
    logic [31:0]           rd_addr_q [$];
    int                    rd_due_q [$];
    int                    cycle;
    int                    wr_beat;
    int                    rd_beat;
    logic [31:0]           rd_line;

    // Lines never written hold the address rule word by word
    function automatic logic [`LINE_BITS-1:0] line_at(input logic [31:0] a);
        logic [`LINE_BITS-1:0] l;
        if (lines.exists(a)) begin
            return lines[a];
        end
        for (int w = 0; w < `LINE_BITS / 32; w++) begin
            l[32 * w +: 32] = (a + 32'(4 * w)) ^ 32'hA5A5_0000;
        end
        return l;
    endfunction

    always @(posedge clk) begin
        logic [`LINE_BITS-1:0] l;
        if (rst) begin
            ready   <= 1'b1;
            rvalid  <= 1'b0;
            rdata   <= '0;
            raddr   <= '0;
            cycle   = 0;
            wr_beat = 0;
            rd_beat = 0;
            rd_addr_q.delete();
            rd_due_q.delete();
        end else begin
            cycle = cycle + 1;
            // Roughly one stall cycle in eight
            ready <= ($urandom_range(7) != 0);
            if (ready && read) begin
                rd_addr_q.push_back(addr);
                rd_due_q.push_back(cycle + LATENCY);
            end
            if (ready && write) begin
                l = line_at(addr);
                l[wr_beat * `BEAT_BITS +: `BEAT_BITS] = wdata;
                lines[addr] = l;
                wr_beat = (wr_beat + 1) % `BEATS;
            end
            rvalid <= 1'b0;
            // Lines go out one after another, beats back to back
            if (rd_beat == 0 && rd_addr_q.size() > 0 && rd_due_q[0] <= cycle) begin
                rd_line = rd_addr_q.pop_front();
                void'(rd_due_q.pop_front());
                rd_beat = `BEATS;
            end
            if (rd_beat > 0) begin
                l = line_at(rd_line);
                rvalid  <= 1'b1;
                raddr   <= rd_line;
                rdata   <= l[(`BEATS - rd_beat) * `BEAT_BITS +: `BEAT_BITS];
                rd_beat = rd_beat - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module tb_mem_subsystem #(
    parameter int SS = 2
);
    localparam int NUM_ROWS = 24;
    localparam int TIMEOUT  = NUM_ROWS * 200;
    localparam bit INST = 1'b0;
    localparam bit DATA = 1'b1;
    localparam bit RD   = 1'b0;
    localparam bit WR   = 1'b1;

    typedef struct packed {
        logic        is_data;
        logic        is_write;
        logic [31:0] addr;
        logic [3:0]  wmask;
        logic [31:0] wdata;
        logic        pair;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic [31:0]           imem_addr;
    logic                  imem_rmask;
    logic [32*SS-1:0]      imem_rdata;
    logic                  imem_resp;
    logic [31:0]           dmem_addr;
    logic                  dmem_rmask;
    logic [3:0]            dmem_wmask;
    logic [31:0]           dmem_wdata;
    logic [31:0]           dmem_rdata;
    logic                  dmem_resp;
    logic [31:0]           bmem_addr;
    logic                  bmem_read;
    logic                  bmem_write;
    logic [`BEAT_BITS-1:0] bmem_wdata;
    logic                  bmem_ready;
    logic [`BEAT_BITS-1:0] bmem_rdata;
    logic [31:0]           bmem_raddr;
    logic                  bmem_rvalid;

    row_t        rows [$];
    string       names [$];
    logic [31:0] shadow [logic [31:0]];
    int          mismatches;
    int          other_fails;
    int          cycles;

    mem_subsystem #(
        .SS(SS)
    ) mem_subsystem_i (
        .clk(clk), .rst(rst),
        .imem_addr(imem_addr), .imem_rmask(imem_rmask),
        .imem_rdata(imem_rdata), .imem_resp(imem_resp),
        .dmem_addr(dmem_addr), .dmem_rmask(dmem_rmask), .dmem_wmask(dmem_wmask),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_resp(dmem_resp),
        .bmem_addr(bmem_addr), .bmem_read(bmem_read), .bmem_write(bmem_write),
        .bmem_wdata(bmem_wdata), .bmem_ready(bmem_ready), .bmem_rdata(bmem_rdata),
        .bmem_raddr(bmem_raddr), .bmem_rvalid(bmem_rvalid)
    );

    bmem_model bmem_model_i (
        .clk(clk), .rst(rst),
        .addr(bmem_addr), .read(bmem_read), .write(bmem_write), .wdata(bmem_wdata),
        .ready(bmem_ready), .rdata(bmem_rdata), .raddr(bmem_raddr), .rvalid(bmem_rvalid)
    );

    always #2 clk = ~clk;

    function automatic void add_row(input string name, input bit is_data, input bit is_write,
                                    input logic [31:0] addr, input logic [3:0] wmask,
                                    input logic [31:0] wdata, input bit pair);
        row_t r;
        r.is_data  = is_data;
        r.is_write = is_write;
        r.addr     = addr;
        r.wmask    = wmask;
        r.wdata    = wdata;
        r.pair     = pair;
        rows.push_back(r);
        names.push_back(name);
    endfunction

    // Same rule as the memory until a data write lands
    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 32'hA5A5_0000;
    endfunction

    function automatic void store_shadow(input logic [31:0] a, input logic [3:0] mask,
                                         input logic [31:0] data);
        logic [31:0] w;
        w = shadow_word(a);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                w[8 * b +: 8] = data[8 * b +: 8];
            end
        end
        shadow[a] = w;
    endfunction

    function automatic void check_data(input int r);
        logic [31:0] a;
        logic [31:0] exp;
        a = {rows[r].addr[31:2], 2'b00};
        if (rows[r].is_write) begin
            store_shadow(a, rows[r].wmask, rows[r].wdata);
        end else begin
            exp = shadow_word(a);
            if (dmem_rdata !== exp) begin
                $display("ERR %s expected %h actual %h", names[r], exp, dmem_rdata);
                mismatches++;
            end
        end
    endfunction

    function automatic void check_inst(input int r);
        logic [31:0] exp;
        logic [31:0] act;
        for (int w = 0; w < SS; w++) begin
            exp = shadow_word(rows[r].addr + 32'(4 * w));
            act = imem_rdata[32 * w +: 32];
            if (act !== exp) begin
                $display("ERR %s word %0d expected %h actual %h", names[r], w, exp, act);
                mismatches++;
            end
        end
    endfunction

    // Launch one data row, one fetch row, or both in the same cycle
    task automatic run_access(input int di, input int ii);
        bit          d_done;
        bit          i_done;
        bit          seen_read;
        logic [31:0] first_rd;
        d_done    = (di < 0);
        i_done    = (ii < 0);
        seen_read = 1'b0;
        first_rd  = '0;
        @(posedge clk);
        if (di >= 0) begin
            dmem_addr  <= rows[di].addr;
            dmem_rmask <= !rows[di].is_write;
            dmem_wmask <= rows[di].is_write ? rows[di].wmask : 4'h0;
            dmem_wdata <= rows[di].wdata;
        end
        if (ii >= 0) begin
            imem_addr  <= rows[ii].addr;
            imem_rmask <= 1'b1;
        end
        while (!(d_done && i_done)) begin
            @(negedge clk);
            if (!seen_read && bmem_read && bmem_ready) begin
                seen_read = 1'b1;
                first_rd  = bmem_addr;
            end
            if (!d_done && dmem_resp) begin
                d_done = 1'b1;
                check_data(di);
            end
            if (!i_done && imem_resp) begin
                i_done = 1'b1;
                check_inst(ii);
            end
            @(posedge clk);
            if (d_done) begin
                dmem_rmask <= 1'b0;
                dmem_wmask <= 4'h0;
            end
            if (i_done) begin
                imem_rmask <= 1'b0;
            end
        end
        if (di >= 0 && ii >= 0 && seen_read && first_rd !== {rows[di].addr[31:5], 5'b0}) begin
            $display("Row %s: instruction line read went to memory before the data line",
                     names[di]);
            other_fails++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
            if (cycles >= TIMEOUT) begin
                $display("Run stopped after %0d cycles without finishing all rows", TIMEOUT);
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    initial begin
        int i;
        void'($urandom(83383));
        clk         = 1'b0;
        rst         = 1'b1;
        imem_addr   = '0;
        imem_rmask  = 1'b0;
        dmem_addr   = '0;
        dmem_rmask  = 1'b0;
        dmem_wmask  = 4'h0;
        dmem_wdata  = '0;
        mismatches  = 0;
        other_fails = 0;
        cycles      = 0;

        add_row("if_miss_a", INST, RD, 32'h0000_1000, 4'h0, 32'h0, 1'b0);
        add_row("if_hit_a",  INST, RD, 32'h0000_1000, 4'h0, 32'h0, 1'b0);
        add_row("if_miss_b", INST, RD, 32'h0000_1040, 4'h0, 32'h0, 1'b0);
        add_row("if_hit_b",  INST, RD, 32'h0000_1040, 4'h0, 32'h0, 1'b0);
        add_row("ld_miss",   DATA, RD, 32'h0000_8004, 4'h0, 32'h0, 1'b0);
        add_row("ld_hit",    DATA, RD, 32'h0000_8008, 4'h0, 32'h0, 1'b0);
        add_row("st_byte0",  DATA, WR, 32'h0000_8004, 4'h1, 32'h0000_00AB, 1'b0);
        add_row("ld_merge0", DATA, RD, 32'h0000_8004, 4'h0, 32'h0, 1'b0);
        add_row("st_half",   DATA, WR, 32'h0000_800C, 4'hC, 32'hBEEF_0000, 1'b0);
        add_row("ld_merge1", DATA, RD, 32'h0000_800C, 4'h0, 32'h0, 1'b0);
        add_row("st_word",   DATA, WR, 32'h0000_8010, 4'hF, 32'h1234_5678, 1'b0);
        // Same index, new tag, so the dirty line leaves first
        add_row("ld_conf",   DATA, RD, 32'h0000_8204, 4'h0, 32'h0, 1'b0);
        add_row("ld_back",   DATA, RD, 32'h0000_8004, 4'h0, 32'h0, 1'b0);
        add_row("ld_back2",  DATA, RD, 32'h0000_8010, 4'h0, 32'h0, 1'b0);
        add_row("st_conf",   DATA, WR, 32'h0000_8208, 4'h6, 32'h00CA_FE00, 1'b0);
        add_row("ld_evict",  DATA, RD, 32'h0000_8000, 4'h0, 32'h0, 1'b0);
        add_row("ld_chk",    DATA, RD, 32'h0000_8208, 4'h0, 32'h0, 1'b0);
        add_row("st_pair",   DATA, WR, 32'h0000_8120, 4'hF, 32'hA1B2_C3D4, 1'b1);
        add_row("if_pair_a", INST, RD, 32'h0000_1080, 4'h0, 32'h0, 1'b0);
        add_row("ld_pair",   DATA, RD, 32'h0000_8120, 4'h0, 32'h0, 1'b1);
        add_row("if_pair_b", INST, RD, 32'h0000_1080, 4'h0, 32'h0, 1'b0);
        add_row("ld_pair2",  DATA, RD, 32'h0000_8400, 4'h0, 32'h0, 1'b1);
        add_row("if_pair_c", INST, RD, 32'h0000_10C0, 4'h0, 32'h0, 1'b0);
        add_row("if_last",   INST, RD, 32'h0000_1000, 4'h0, 32'h0, 1'b0);

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        i = 0;
        while (i < rows.size()) begin
            if (rows[i].is_data && rows[i].pair) begin
                run_access(i, i + 1);
                i = i + 2;
            end else if (rows[i].is_data) begin
                run_access(i, -1);
                i = i + 1;
            end else begin
                run_access(-1, i);
                i = i + 1;
            end
        end

        repeat (2) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d other failures", mismatches, other_fails);
        if (mismatches == 0 && other_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/mem_pkg.sv
source/inst_cache.sv
source/data_cache.sv
source/cache_arbiter.sv
source/mem_subsystem.sv
testbench/bmem_model.sv
testbench/tb_mem_subsystem.sv
